// ==== Makefile ====
TOP := tb_ex_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx 'All checks passed'

clean:
	rm -rf obj_dir

// ==== dv/ex_stage_properties.sv ====
module ex_stage_properties import ex_pkg::*; (
    input logic    clk,
    input logic    arst_n,
    input logic    stall,
    input ex_mem_t mem
);

    timeunit 1ns;
    timeprecision 1ps;

    int stall_run;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stall_run <= 0;
        end else begin
            stall_run <= stall ? stall_run + 1 : 0;
        end
    end

    stall_bubble: assert property (@(posedge clk) disable iff (!arst_n)
        stall |=> !mem.valid)
        else $error("mem.valid high after a stalled cycle");

    // Load cycle plus the full divide.
    stall_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        !(stall && stall_run >= DIV_STEPS + 1))
        else $error("stall held longer than one divide");

    reset_empty: assert property (@(posedge clk) $rose(arst_n) |=> !mem.valid)
        else $error("mem.valid high right after reset");

endmodule

bind ex_stage ex_stage_properties ex_stage_properties_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .stall  (stall),
    .mem    (mem)
);

// ==== dv/ex_stimulus.txt ====
# name alu src jmp br f3 jalr pc1 mul div mulc divc pc rd1 rd2 imm fwd1 fwd2 res_w
# then expected ex_out write_data pc_target pc_src; all values hex
add      0 0 0 0 0 0 0 0 0 0 0  100 5 7 0 0 0 0  c 7 100 0
sll      5 0 0 0 0 0 0 0 0 0 0  100 1 1f 0 0 0 0  80000000 1f 100 0
srl      6 0 0 0 0 0 0 0 0 0 0  100 80000000 4 0 0 0 0  8000000 4 100 0
sra      7 0 0 0 0 0 0 0 0 0 0  100 80000000 4 0 0 0 0  f8000000 4 100 0
slt      8 0 0 0 0 0 0 0 0 0 0  100 ffffffff 1 0 0 0 0  1 1 100 0
sltu     9 0 0 0 0 0 0 0 0 0 0  100 ffffffff 1 0 0 0 0  0 1 100 0
lui      a 1 0 0 0 0 0 0 0 0 0  100 0 0 12345000 0 0 0  12345000 0 12345100 0
auipc    0 1 0 0 0 0 1 0 0 0 0  1000 0 0 2000 0 0 0  3000 0 3000 0
fwd_wb   3 0 0 0 0 0 0 0 0 0 0  100 ffff f 0 1 0 a0  af f 100 0
fwd_mem  0 0 0 0 0 0 0 0 0 0 0  100 0 5 0 2 1 1  b0 1 100 0
fwd_zero 4 0 0 0 0 0 0 0 0 0 0  100 55 66 0 0 3 0  55 0 100 0
blt      1 0 0 1 4 0 0 0 0 0 0  200 ffffffff 1 40 0 0 0  fffffffe 1 240 1
bgeu     1 0 0 1 7 0 0 0 0 0 0  200 1 ffffffff 40 0 0 0  2 ffffffff 240 0
jal      0 1 1 0 0 0 1 0 0 0 0  300 0 0 80 0 0 0  380 0 380 1
jalr     0 1 1 0 0 1 0 0 0 0 0  300 1001 0 10 0 0 0  1011 0 1010 1
mul      0 0 0 0 0 0 0 1 0 0 0  100 fffffffe 3 0 0 0 0  fffffffa 3 100 0
mulh     0 0 0 0 0 0 0 1 0 1 0  100 fffffffe 3 0 0 0 0  ffffffff 3 100 0
mulhsu   0 0 0 0 0 0 0 1 0 2 0  100 fffffffe ffffffff 0 0 0 0  fffffffe ffffffff 100 0
mulhu    0 0 0 0 0 0 0 1 0 3 0  100 fffffffe ffffffff 0 0 0 0  fffffffd ffffffff 100 0
div      0 0 0 0 0 0 0 0 1 0 0  100 ffffffec 3 0 0 0 0  fffffffa 3 100 0
divu     0 0 0 0 0 0 0 0 1 0 1  100 14 3 0 0 0 0  6 3 100 0
rem      0 0 0 0 0 0 0 0 1 0 2  100 ffffffec 3 0 0 0 0  fffffffe 3 100 0
remu     0 0 0 0 0 0 0 0 1 0 3  100 14 3 0 0 0 0  2 3 100 0
div_zero 0 0 0 0 0 0 0 0 1 0 1  100 7 0 0 0 0 0  ffffffff 0 100 0
rem_zero 0 0 0 0 0 0 0 0 1 0 2  100 fffffff9 0 0 0 0 0  fffffff9 0 100 0
div_ovf  0 0 0 0 0 0 0 0 1 0 0  100 80000000 ffffffff 0 0 0 0  80000000 ffffffff 100 0

// ==== dv/tb_ex_stage.sv ====
module tb_ex_stage import ex_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FIELDS  = 22;
    localparam int DIV_LATENCY = 34; // Load, 32 steps, result.
    localparam int DIV_STALLS  = 33;

    typedef struct packed {
        ex_ctrl_t ctrl;
        ex_data_t data;
        fwd_sel_t fwd_rs1;
        fwd_sel_t fwd_rs2;
        word_t    result_w;
        ex_mem_t  exp;
    } vec_t;

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    ex_ctrl_t ctrl;
    ex_data_t data;
    fwd_sel_t fwd_rs1;
    fwd_sel_t fwd_rs2;
    word_t    result_w;
    logic     stall;
    ex_mem_t  mem;

    vec_t  vecs[$];
    string names[$];
    int    cycles      = 0;
    int    cycle_limit = 20;
    int    passed      = 0;
    int    failed      = 0;
    int    load_errors = 0;

    ex_stage ex_stage_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .ctrl     (ctrl),
        .data     (data),
        .fwd_rs1  (fwd_rs1),
        .fwd_rs2  (fwd_rs2),
        .result_w (result_w),
        .stall    (stall),
        .mem      (mem)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: no result after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic load_vectors();
        int          fd;
        int          got;
        string       name;
        string       line;
        logic [31:0] f [NUM_FIELDS];
        vec_t        v;
        fd = $fopen("dv/ex_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/ex_stimulus.txt");
            load_errors++;
            return;
        end
        while ($fscanf(fd, "%s", name) == 1) begin
            if (name.substr(0, 0) == "#") begin
                void'($fgets(line, fd)); // Rest of a comment line.
            end else begin
                got = 0;
                for (int i = 0; i < NUM_FIELDS; i++) begin
                    got += $fscanf(fd, "%h", f[i]);
                end
                if (got != NUM_FIELDS) begin
                    $display("Stimulus line for %s has too few fields", name);
                    load_errors++;
                end
                v.ctrl = {f[0][3:0], f[1][0], f[2][0], f[3][0], f[4][2:0], f[5][0],
                          f[6][0], f[7][0], f[8][0], f[9][1:0], f[10][1:0]};
                v.data     = {f[11], f[12], f[13], f[14]};
                v.fwd_rs1  = f[15][1:0];
                v.fwd_rs2  = f[16][1:0];
                v.result_w = f[17];
                v.exp      = {1'b1, f[21][0], f[18], f[19], f[20]};
                vecs.push_back(v);
                names.push_back(name);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_word(input string name, input string field, input word_t exp_val,
                              input word_t act_val, inout int bad);
        if (act_val !== exp_val) begin
            $display("MISMATCH %s %s expected %h actual %h", name, field, exp_val, act_val);
            bad++;
        end
    endtask

    task automatic verify_count(input string name, input string field, input int exp_val,
                                input int act_val, inout int bad);
        if (act_val != exp_val) begin
            $display("MISMATCH %s %s expected %0d actual %0d", name, field, exp_val, act_val);
            bad++;
        end
    endtask

    task automatic run_test(input string name, input vec_t v);
        int latency;
        int stalls;
        int bad;
        @(posedge clk);
        #1;
        bad = 0;
        // The edge just taken saw in_valid low.
        check_word(name, "idle valid", '0, word_t'(mem.valid), bad);
        in_valid = 1'b1;
        ctrl     = v.ctrl;
        data     = v.data;
        fwd_rs1  = v.fwd_rs1;
        fwd_rs2  = v.fwd_rs2;
        result_w = v.result_w;
        latency  = 0;
        stalls   = 0;
        // Inputs stay put while stall is high.
        do begin
            @(negedge clk);
            if (stall) stalls++;
            @(posedge clk);
            #1;
            latency++;
        end while (!mem.valid);
        in_valid = 1'b0;
        check_word(name, "ex_out", v.exp.ex_out, mem.ex_out, bad);
        check_word(name, "write_data", v.exp.write_data, mem.write_data, bad);
        check_word(name, "pc_target", v.exp.pc_target, mem.pc_target, bad);
        check_word(name, "pc_src", word_t'(v.exp.pc_src), word_t'(mem.pc_src), bad);
        verify_count(name, "latency", v.ctrl.div_en ? DIV_LATENCY : 1, latency, bad);
        verify_count(name, "stall cycles", v.ctrl.div_en ? DIV_STALLS : 0, stalls, bad);
        if (bad == 0) begin
            passed++;
            $display("PASS %s", name);
        end else begin
            failed++;
            $display("FAIL %s with %0d mismatches", name, bad);
        end
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        ctrl     = '0;
        data     = '0;
        fwd_rs1  = FWD_REG;
        fwd_rs2  = FWD_REG;
        result_w = '0;
        load_vectors();
        cycle_limit = 40 * vecs.size() + 20;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        foreach (vecs[i]) run_test(names[i], vecs[i]);
        $display("Tests: %0d  passed: %0d  failed: %0d  load errors: %0d",
                 vecs.size(), passed, failed, load_errors);
        if (failed == 0 && load_errors == 0 && vecs.size() > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/ex_pkg.sv
verilog/alu.sv
verilog/mul_unit.sv
verilog/div_unit.sv
verilog/execute.sv
verilog/ex_mem_reg.sv
verilog/ex_stage.sv
dv/ex_stage_properties.sv
dv/tb_ex_stage.sv

// ==== verilog/alu.sv ====
module alu import ex_pkg::*; (
    input  word_t     op_a,
    input  word_t     op_b,
    input  alu_ctrl_t alu_ctrl,
    input  funct3_t   funct3,
    output word_t     result,
    output logic      cond
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = op_b[4:0];
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;
    assign eq    = op_a == op_b;

    always_comb begin
        case (alu_ctrl)
            ALU_ADD:   result = op_a + op_b;
            ALU_SUB:   result = op_a - op_b;
            ALU_AND:   result = op_a & op_b;
            ALU_OR:    result = op_a | op_b;
            ALU_XOR:   result = op_a ^ op_b;
            ALU_SLL:   result = op_a << shamt;
            ALU_SRL:   result = op_a >> shamt;
            ALU_SRA:   result = $signed(op_a) >>> shamt;
            ALU_SLT:   result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:  result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_PASSB: result = op_b;
            default:   result = '0;
        endcase
    end

    // Branch compare, independent of alu_ctrl.
    always_comb begin
        case (funct3)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = !eq;
            F3_BLT:  cond = lt_s;
            F3_BGE:  cond = !lt_s;
            F3_BLTU: cond = lt_u;
            F3_BGEU: cond = !lt_u;
            default: cond = 1'b0; // Not a branch encoding.
        endcase
    end

endmodule

// ==== verilog/div_unit.sv ====
module div_unit import ex_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      start,
    input  div_ctrl_t div_ctrl,
    input  word_t     numerator,
    input  word_t     denominator,
    output word_t     result,
    output logic      busy
);

    div_state_t           state;
    logic [DIV_CNT_W-1:0] step;
    logic                 load;
    logic                 is_signed;
    word_t                num_abs;
    word_t                den_abs;
    word_t                quo;
    word_t                rem;
    word_t                dvsr;
    word_t                dividend;
    logic                 neg_quo;
    logic                 neg_rem;
    logic                 is_rem;
    logic                 by_zero;
    logic                 overflow;
    logic [XLEN:0]        partial;
    logic [XLEN:0]        diff;
    word_t                quo_out;
    word_t                rem_out;

    assign load      = (state == DIV_IDLE) && start;
    assign busy      = load || (state == DIV_RUN);
    assign is_signed = (div_ctrl == DIV_S) || (div_ctrl == REM_S);
    assign num_abs   = (is_signed && numerator[XLEN-1]) ? -numerator : numerator;
    assign den_abs   = (is_signed && denominator[XLEN-1]) ? -denominator : denominator;

    // One restoring step.
    assign partial = {rem, quo[XLEN-1]};
    assign diff    = partial - {1'b0, dvsr};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= DIV_IDLE;
            step  <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        state <= DIV_RUN;
                        step  <= '0;
                    end
                end
                DIV_RUN: begin
                    step <= step + 1'b1;
                    if (step == DIV_CNT_W'(DIV_STEPS - 1)) state <= DIV_DONE;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            quo      <= num_abs; // Dividend shifts out of the quotient register.
            rem      <= '0;
            dvsr     <= den_abs;
            dividend <= numerator;
            neg_quo  <= is_signed && (numerator[XLEN-1] ^ denominator[XLEN-1]);
            neg_rem  <= is_signed && numerator[XLEN-1];
            is_rem   <= (div_ctrl == REM_S) || (div_ctrl == REM_U);
            by_zero  <= (denominator == '0);
            overflow <= is_signed && (numerator == INT_MIN) && (denominator == '1);
        end else if (state == DIV_RUN) begin
            if (!diff[XLEN]) begin
                rem <= diff[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end else begin
                rem <= partial[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b0};
            end
        end
    end

    // Sign fixup and special cases, valid in DIV_DONE.
    assign quo_out = by_zero  ? '1 :
                     overflow ? dividend :
                     neg_quo  ? -quo : quo;
    assign rem_out = by_zero  ? dividend :
                     overflow ? '0 :
                     neg_rem  ? -rem : rem;
    assign result  = is_rem ? rem_out : quo_out;

endmodule

// ==== verilog/ex_mem_reg.sv ====
module ex_mem_reg import ex_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  ex_mem_t ex_res,
    input  logic    hold,
    output ex_mem_t mem
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem <= '0;
        end else if (hold) begin
            // Bubble. Data stays put so ex_out_m is stable.
            mem.valid  <= 1'b0;
            mem.pc_src <= 1'b0;
        end else begin
            mem <= ex_res;
        end
    end

endmodule

// ==== verilog/ex_pkg.sv ====
package ex_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [3:0]      alu_ctrl_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [1:0]      fwd_sel_t;
    typedef logic [1:0]      mul_ctrl_t;
    typedef logic [1:0]      div_ctrl_t;

    localparam alu_ctrl_t ALU_ADD   = 4'd0;
    localparam alu_ctrl_t ALU_SUB   = 4'd1;
    localparam alu_ctrl_t ALU_AND   = 4'd2;
    localparam alu_ctrl_t ALU_OR    = 4'd3;
    localparam alu_ctrl_t ALU_XOR   = 4'd4;
    localparam alu_ctrl_t ALU_SLL   = 4'd5;
    localparam alu_ctrl_t ALU_SRL   = 4'd6;
    localparam alu_ctrl_t ALU_SRA   = 4'd7;
    localparam alu_ctrl_t ALU_SLT   = 4'd8;
    localparam alu_ctrl_t ALU_SLTU  = 4'd9;
    localparam alu_ctrl_t ALU_PASSB = 4'd10; // LUI.

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // Code 2'b11 selects zero.
    localparam fwd_sel_t FWD_REG = 2'b00;
    localparam fwd_sel_t FWD_WB  = 2'b01;
    localparam fwd_sel_t FWD_MEM = 2'b10;

    localparam mul_ctrl_t MUL_LO  = 2'd0;
    localparam mul_ctrl_t MUL_HSS = 2'd1;
    localparam mul_ctrl_t MUL_HSU = 2'd2;
    localparam mul_ctrl_t MUL_HUU = 2'd3;

    localparam div_ctrl_t DIV_S = 2'd0;
    localparam div_ctrl_t DIV_U = 2'd1;
    localparam div_ctrl_t REM_S = 2'd2;
    localparam div_ctrl_t REM_U = 2'd3;

    localparam int    DIV_STEPS = 32;
    localparam int    DIV_CNT_W = $clog2(DIV_STEPS);
    localparam word_t INT_MIN   = {1'b1, {(XLEN-1){1'b0}}};

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

    typedef struct packed {
        alu_ctrl_t alu_ctrl;
        logic      alu_src;
        logic      jump;
        logic      branch;
        funct3_t   funct3;
        logic      jalr;
        logic      op1_pc;
        logic      mul_en;
        logic      div_en;
        mul_ctrl_t mul_ctrl;
        div_ctrl_t div_ctrl;
    } ex_ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t rd1;
        word_t rd2;
        word_t imm;
    } ex_data_t;

    typedef struct packed {
        logic  valid;
        logic  pc_src;
        word_t ex_out;
        word_t write_data;
        word_t pc_target;
    } ex_mem_t;

endpackage

// ==== verilog/ex_stage.sv ====
module ex_stage import ex_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  ex_ctrl_t ctrl,
    input  ex_data_t data,
    input  fwd_sel_t fwd_rs1,
    input  fwd_sel_t fwd_rs2,
    input  word_t    result_w,
    output logic     stall,
    output ex_mem_t  mem
);

    ex_mem_t ex_res;
    logic    busy;
    word_t   ex_out_m;

    assign stall    = busy;
    assign ex_out_m = mem.ex_out; // Memory-stage forwarding value.

    execute execute_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .ctrl     (ctrl),
        .data     (data),
        .fwd_rs1  (fwd_rs1),
        .fwd_rs2  (fwd_rs2),
        .result_w (result_w),
        .ex_out_m (ex_out_m),
        .ex_res   (ex_res),
        .busy     (busy)
    );

    ex_mem_reg ex_mem_reg_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .ex_res (ex_res),
        .hold   (busy),
        .mem    (mem)
    );

endmodule

// ==== verilog/execute.sv ====
module execute import ex_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  ex_ctrl_t ctrl,
    input  ex_data_t data,
    input  fwd_sel_t fwd_rs1,
    input  fwd_sel_t fwd_rs2,
    input  word_t    result_w,
    input  word_t    ex_out_m,
    output ex_mem_t  ex_res,
    output logic     busy
);

    word_t rs1_fwd;
    word_t rs2_fwd;
    word_t src_a;
    word_t src_b;
    word_t alu_res;
    word_t mul_res;
    word_t div_res;
    logic  alu_cond;

    function automatic word_t fwd_pick(fwd_sel_t sel, word_t reg_val, word_t wb_val,
                                       word_t mem_val);
        case (sel)
            FWD_REG: return reg_val;
            FWD_WB:  return wb_val;
            FWD_MEM: return mem_val;
            default: return '0;
        endcase
    endfunction

    assign rs1_fwd = fwd_pick(fwd_rs1, data.rd1, result_w, ex_out_m);
    assign rs2_fwd = fwd_pick(fwd_rs2, data.rd2, result_w, ex_out_m);

    assign src_a = ctrl.op1_pc  ? data.pc  : rs1_fwd; // AUIPC, JAL.
    assign src_b = ctrl.alu_src ? data.imm : rs2_fwd;

    alu alu_inst (
        .op_a     (src_a),
        .op_b     (src_b),
        .alu_ctrl (ctrl.alu_ctrl),
        .funct3   (ctrl.funct3),
        .result   (alu_res),
        .cond     (alu_cond)
    );

    mul_unit mul_unit_inst (
        .op_a     (src_a),
        .op_b     (src_b),
        .mul_ctrl (ctrl.mul_ctrl),
        .result   (mul_res)
    );

    div_unit div_unit_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (in_valid && ctrl.div_en),
        .div_ctrl    (ctrl.div_ctrl),
        .numerator   (src_a),
        .denominator (src_b),
        .result      (div_res),
        .busy        (busy)
    );

    assign ex_res.valid      = in_valid;
    assign ex_res.pc_src     = ctrl.jump || (ctrl.branch && alu_cond);
    assign ex_res.ex_out     = ctrl.div_en ? div_res :
                               ctrl.mul_en ? mul_res : alu_res;
    assign ex_res.write_data = rs2_fwd;
    // JALR clears bit 0 of the sum.
    assign ex_res.pc_target  = ctrl.jalr ? {alu_res[XLEN-1:1], 1'b0} : data.pc + data.imm;

endmodule

// ==== verilog/mul_unit.sv ====
module mul_unit import ex_pkg::*; (
    input  word_t     op_a,
    input  word_t     op_b,
    input  mul_ctrl_t mul_ctrl,
    output word_t     result
);

    logic                   sign_a;
    logic                   sign_b;
    logic signed [XLEN:0]   a_ext;
    logic signed [XLEN:0]   b_ext;
    logic [2*XLEN-1:0]      prod;

    // Low word does not depend on signedness.
    assign sign_a = (mul_ctrl == MUL_HSS) || (mul_ctrl == MUL_HSU);
    assign sign_b = (mul_ctrl == MUL_HSS);

    assign a_ext = {sign_a & op_a[XLEN-1], op_a};
    assign b_ext = {sign_b & op_b[XLEN-1], op_b};
    assign prod  = (2*XLEN)'(a_ext * b_ext);

    assign result = (mul_ctrl == MUL_LO) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];

endmodule
